// File: fp32Pkg.sv
// FP32 divider package
`default_nettype none

package fp32Pkg;

	// --------------------------------------------------
	// format constants
	// --------------------------------------------------
	// exponent msb index
	localparam int EMSB = 7;
	// fraction msb index, hidden bit excluded
	localparam int FMSB = 22;
	// extended fraction msb, two integer bits on top
	localparam int FX = 2 * FMSB + 3;
	localparam int BIAS = 127;

	// extra low-order bits carried by the mantissa divider
	localparam int FADD = 9;
	// quotient width, twice the divider operand width
	localparam int QBITS = (FMSB + FADD) * 2;

	// ld to done at the top:
	// decode 1, iterations QBITS/2, done pulse 1, core tail 3, normalize 1, round 1
	localparam int DIV_LATENCY = 38;

	// full quiet-NaN fractions, quiet bit included
	// infinity over infinity
	localparam logic [FMSB:0] QINFDIV = 23'h400002;
	// zero over zero
	localparam logic [FMSB:0] QZEROZERO = 23'h400003;

	// --------------------------------------------------
	// operand and result structs
	// --------------------------------------------------
	typedef struct packed {
		logic sign;
		logic [EMSB:0] exp;
		logic [FMSB:0] frac;
	} FP32;

	// unnormalized quotient, frac[FX:FX-1] is the integer part
	typedef struct packed {
		logic sign;
		logic [EMSB:0] exp;
		logic [FX:0] frac;
	} FP32X;

	// normalized value with rounding bits, hidden bit implied
	typedef struct packed {
		logic sign;
		logic [EMSB:0] exp;
		logic [FMSB:0] frac;
		logic guard;
		logic round;
		logic sticky;
	} FP32N;

	typedef enum logic [2:0] {
		rmNearestEven = 3'd0,
		rmTowardZero  = 3'd1,
		rmDown        = 3'd2,
		rmUp          = 3'd3,
		rmNearestMax  = 3'd4
	} roundMode_e;

	typedef enum logic [1:0] {
		dsIdle = 2'd0,
		dsRun  = 2'd1,
		dsDone = 2'd2
	} divState_e;

endpackage

`default_nettype wire

// File: fpDecomp32Reg.sv
// Registered operand decode
`timescale 1ns/1ps
`default_nettype none

module fpDecomp32Reg import fp32Pkg::*; (
	input  logic clk,
	input  logic ce,
	input  FP32 i,
	output logic sgn,
	output logic xz,
	output logic vz,
	output logic inf,
	output logic nan,
	output logic [EMSB:0] exp,
	output logic [FMSB+1:0] fract
);

	logic expZero;
	logic expOnes;
	logic fracZero;

	// field classification
	assign expZero = ~|i.exp;
	assign expOnes = &i.exp;
	assign fracZero = ~|i.frac;

	always_ff @(posedge clk) begin
		if (ce) begin
			sgn <= i.sign;
			exp <= i.exp;
			// hidden bit only for a nonzero exponent
			fract <= {~expZero, i.frac};
			xz <= expZero;
			// true zero, both fields clear
			vz <= expZero & fracZero;
			inf <= expOnes & fracZero;
			nan <= expOnes & ~fracZero;
		end
	end

endmodule

`default_nettype wire

// File: fpMantDivider.sv
// Radix-2 restoring mantissa divider
`timescale 1ns/1ps
`default_nettype none

module fpMantDivider import fp32Pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic ce,
	input  logic ld,
	input  logic [FMSB+FADD-1:0] a,
	input  logic [FMSB+FADD-1:0] b,
	output logic [QBITS-1:0] q,
	output logic [7:0] lzcnt,
	output logic done
);

	divState_e state;
	// iterations left, two quotient bits each
	logic [4:0] cnt;

	logic [FMSB+FADD-1:0] bReg;
	logic [FMSB+FADD-1:0] rem;
	logic [FMSB+FADD-1:0] remNext;
	logic [FMSB+FADD-1:0] r;
	// dividend shifts out the top while quotient bits enter the bottom
	logic [QBITS-1:0] qd;
	logic [QBITS-1:0] qdNext;
	logic [QBITS-1:0] d;
	logic [FMSB+FADD:0] t;
	logic qb;
	logic [7:0] lz;
	logic found;

	// --------------------------------------------------
	// two shift-subtract steps per clock
	// --------------------------------------------------
	always_comb begin
		r = rem;
		d = qd;
		for (int k = 0; k < 2; k++) begin
			// partial remainder stays below b, so one subtract is enough
			t = {r, d[QBITS-1]};
			qb = (t >= {1'b0, bReg});
			if (qb) begin
				t = t - {1'b0, bReg};
			end
			r = t[FMSB+FADD-1:0];
			d = {d[QBITS-2:0], qb};
		end
		remNext = r;
		qdNext = d;
	end

	// leading zeros of the finished quotient
	always_comb begin
		lz = '0;
		found = 1'b0;
		for (int k = QBITS - 1; k >= 0; k--) begin
			if (!found) begin
				if (qd[k]) begin
					found = 1'b1;
				end else begin
					lz = lz + 8'd1;
				end
			end
		end
	end

	// --------------------------------------------------
	// control
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= dsIdle;
			cnt <= '0;
			done <= 1'b0;
		end else if (ce) begin
			done <= 1'b0;
			case (state)
				dsIdle: begin
					// a load anywhere else is dropped
					if (ld) begin
						cnt <= 5'(QBITS / 2 - 1);
						state <= dsRun;
					end
				end
				dsRun: begin
					if (cnt == '0) begin
						state <= dsDone;
					end else begin
						cnt <= cnt - 5'd1;
					end
				end
				dsDone: begin
					done <= 1'b1;
					state <= dsIdle;
				end
				default: state <= dsIdle;
			endcase
		end
	end

	// datapath
	always_ff @(posedge clk) begin
		if (ce) begin
			if (state == dsIdle && ld) begin
				bReg <= b;
				qd <= {a, {(FMSB + FADD){1'b0}}};
				rem <= '0;
			end else if (state == dsRun) begin
				rem <= remNext;
				qd <= qdNext;
			end else if (state == dsDone) begin
				// nonzero remainder folds into the lsb as sticky
				q <= {qd[QBITS-1:1], qd[0] | (|rem)};
				lzcnt <= lz;
			end
		end
	end

endmodule

`default_nettype wire

// File: fpDivide32.sv
// FP32 divide core
`timescale 1ns/1ps
`default_nettype none

module fpDivide32 import fp32Pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic ce,
	input  logic ld,
	input  FP32 a,
	input  FP32 b,
	output FP32X o,
	output logic done,
	output logic signExe,
	output logic overflow,
	output logic underflow
);

	logic ldAcc;
	logic ld1;

	// decoded operands
	logic sa;
	logic sb;
	logic aXz;
	logic bXz;
	logic aInf;
	logic bInf;
	logic aNan;
	logic bNan;
	logic [EMSB:0] xa;
	logic [EMSB:0] xb;
	logic [FMSB+1:0] fracta;
	logic [FMSB+1:0] fractb;

	logic [QBITS-1:0] q;
	logic [QBITS-1:0] divo1;
	logic [7:0] lzcnt;
	logic divDone;
	logic dDone1;
	logic dDone2;

	// biased exponent, two extra bits for sign and overflow
	logic [EMSB+2:0] ex1;
	logic over;
	logic under;
	logic special;

	// only one division at a time
	assign ldAcc = ld & done;

	// --------------------------------------------------
	// operand decode, captured on an accepted load
	// --------------------------------------------------
	fpDecomp32Reg u1a (
		.clk(clk), .ce(ce & ldAcc), .i(a), .sgn(sa), .xz(aXz), .vz(),
		.inf(aInf), .nan(aNan), .exp(xa), .fract(fracta)
	);
	fpDecomp32Reg u1b (
		.clk(clk), .ce(ce & ldAcc), .i(b), .sgn(sb), .xz(bXz), .vz(),
		.inf(bInf), .nan(bNan), .exp(xb), .fract(fractb)
	);

	// mantissas padded with low zeros to the divider width
	fpMantDivider u2 (
		.clk(clk), .rst(rst), .ce(ce), .ld(ld1),
		.a({fracta, {(FADD - 2){1'b0}}}),
		.b({fractb, {(FADD - 2){1'b0}}}),
		.q(q), .lzcnt(lzcnt), .done(divDone)
	);

	// load delay and done pulse tail
	always_ff @(posedge clk) begin
		if (rst) begin
			ld1 <= 1'b0;
			dDone1 <= 1'b0;
			dDone2 <= 1'b0;
		end else if (ce) begin
			ld1 <= ldAcc;
			dDone1 <= divDone;
			dDone2 <= dDone1;
		end
	end

	// leading one lands one below the top, integer part reads 01
	assign divo1 = q << (lzcnt - 8'd1);

	// --------------------------------------------------
	// exponent and range checks
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (ce) begin
			// quotient of equal mantissas has lzcnt = QBITS-1-(FMSB+FADD)
			ex1 <= {2'b00, xa} - {2'b00, xb}
				+ 10'(BIAS + QBITS - 1 - FMSB - FADD) - {2'b00, lzcnt};
			// at or above all ones
			over <= ~ex1[EMSB+2] & (ex1[EMSB+1] | (&ex1[EMSB:0]));
			// negative or zero, flushed
			under <= ex1[EMSB+2] | (ex1 == '0);
		end
	end

	// zero exponent counts as zero, denormals flush
	assign special = aNan | bNan | aInf | bInf | aXz | bXz;

	// --------------------------------------------------
	// result select
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			o <= '0;
			done <= 1'b1;
			signExe <= 1'b0;
			overflow <= 1'b0;
			underflow <= 1'b0;
		end else if (ce) begin
			if (ldAcc) begin
				done <= 1'b0;
			end
			if (dDone2) begin
				done <= 1'b1;
				o.sign <= sa ^ sb;
				if (aNan) begin
					// quiet the incoming payload
					o.exp <= '1;
					o.frac <= {2'b01, 1'b1, fracta[FMSB-1:0], {(FMSB + 1){1'b0}}};
				end else if (bNan) begin
					o.exp <= '1;
					o.frac <= {2'b01, 1'b1, fractb[FMSB-1:0], {(FMSB + 1){1'b0}}};
				end else if (aInf & bInf) begin
					o.exp <= '1;
					o.frac <= {2'b01, QINFDIV, {(FMSB + 1){1'b0}}};
				end else if (aXz & bXz) begin
					o.exp <= '1;
					o.frac <= {2'b01, QZEROZERO, {(FMSB + 1){1'b0}}};
				end else if (bInf | aXz) begin
					// x/inf and 0/x
					o.exp <= '0;
					o.frac <= '0;
				end else if (bXz | aInf) begin
					// x/0 and inf/x
					o.exp <= '1;
					o.frac <= {2'b01, {(FX - 1){1'b0}}};
				end else if (over) begin
					// largest finite with all rounding bits set,
					// the rounder then picks infinity or max by mode
					o.exp <= {{EMSB{1'b1}}, 1'b0};
					o.frac <= {2'b01, {(FX - 1){1'b1}}};
				end else if (under) begin
					o.exp <= '0;
					o.frac <= '0;
				end else begin
					o.exp <= ex1[EMSB:0];
					o.frac <= divo1[QBITS-1 -: FX + 1];
				end
				signExe <= sa & sb;
				overflow <= over & ~special;
				underflow <= under & ~over & ~special;
			end
		end
	end

endmodule

`default_nettype wire

// File: fpNormalize32.sv
// Quotient normalizer
`timescale 1ns/1ps
`default_nettype none

module fpNormalize32 import fp32Pkg::*; (
	input  logic clk,
	input  logic ce,
	input  logic underI,
	input  FP32X i,
	output FP32N o
);

	// shift needed when the 2's place is clear
	logic sh;
	logic [FX:0] m2;
	logic [EMSB:0] expN;

	// hidden bit ends up at FX after at most one left shift
	assign sh = ~i.frac[FX];
	assign m2 = i.frac << sh;

	// integer part 1x moves the point right, so exponent goes up
	assign expN = i.exp + {{EMSB{1'b0}}, ~sh};

	always_ff @(posedge clk) begin
		if (ce) begin
			if (underI) begin
				// flushed, keep the sign
				o <= '{sign: i.sign, default: '0};
			end else begin
				o <= '{
					sign:   i.sign,
					exp:    expN,
					frac:   m2[FX-1 -: FMSB + 1],
					guard:  m2[FX-FMSB-2],
					round:  m2[FX-FMSB-3],
					// everything below round
					sticky: |m2[FX-FMSB-4:0]
				};
			end
		end
	end

endmodule

`default_nettype wire

// File: fpRound32.sv
// FP32 rounder
`timescale 1ns/1ps
`default_nettype none

module fpRound32 import fp32Pkg::*; (
	input  logic clk,
	input  logic ce,
	input  roundMode_e rm,
	input  FP32N i,
	output FP32 o
);

	logic inexact;
	logic inc;
	// fraction plus carry out
	logic [FMSB+1:0] sum;
	logic [EMSB:0] expR;

	assign inexact = i.guard | i.round | i.sticky;

	// increment decision
	always_comb begin
		case (rm)
			rmNearestEven: inc = i.guard & (i.round | i.sticky | i.frac[0]);
			rmTowardZero:  inc = 1'b0;
			rmDown:        inc = i.sign & inexact;
			rmUp:          inc = ~i.sign & inexact;
			// ties away from zero
			rmNearestMax:  inc = i.guard;
			default:       inc = 1'b0;
		endcase
	end

	assign sum = {1'b0, i.frac} + {{(FMSB + 1){1'b0}}, inc};
	// carry out leaves the fraction at zero
	assign expR = i.exp + {{EMSB{1'b0}}, sum[FMSB+1]};

	always_ff @(posedge clk) begin
		if (ce) begin
			if (&i.exp) begin
				// NaN and infinity untouched
				o <= '{sign: i.sign, exp: i.exp, frac: i.frac};
			end else if (&expR) begin
				// rounded up into infinity; modes without an increment
				// never get here and keep the largest finite value
				o <= '{sign: i.sign, exp: '1, frac: '0};
			end else begin
				o <= '{sign: i.sign, exp: expR, frac: sum[FMSB:0]};
			end
		end
	end

endmodule

`default_nettype wire

// File: fpDivide32nr.sv
// FP32 divider top
`timescale 1ns/1ps
`default_nettype none

module fpDivide32nr import fp32Pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic ce,
	input  logic ld,
	input  roundMode_e rm,
	input  FP32 a,
	input  FP32 b,
	output FP32 out,
	output logic done,
	output logic signExe,
	output logic overflow,
	output logic underflow
);

	// status that follows the result down the pipe
	typedef struct packed {
		logic done;
		logic signExe;
		logic overflow;
		logic underflow;
	} divStat_t;

	FP32X coreO;
	FP32N normO;
	divStat_t coreStat;
	divStat_t stat1;
	divStat_t stat2;

	// core accepts only while the visible result is valid
	fpDivide32 u1 (
		.clk(clk), .rst(rst), .ce(ce), .ld(ld & done), .a(a), .b(b), .o(coreO),
		.done(coreStat.done), .signExe(coreStat.signExe),
		.overflow(coreStat.overflow), .underflow(coreStat.underflow)
	);

	fpNormalize32 u2 (
		.clk(clk), .ce(ce), .underI(coreStat.underflow), .i(coreO), .o(normO)
	);

	fpRound32 u3 (
		.clk(clk), .ce(ce), .rm(rm), .i(normO), .o(out)
	);

	// two stages to line up with normalize and round
	always_ff @(posedge clk) begin
		if (rst) begin
			stat1 <= '{done: 1'b1, default: 1'b0};
			stat2 <= '{done: 1'b1, default: 1'b0};
		end else if (ce) begin
			stat1 <= coreStat;
			stat2 <= stat1;
		end
	end

	// falls right after a load, rises with the rounded result
	assign done = coreStat.done & stat2.done;
	assign signExe = stat2.signExe;
	assign overflow = stat2.overflow;
	assign underflow = stat2.underflow;

endmodule

`default_nettype wire

// File: tbFpDivide32.sv
// FP32 divider testbench
`timescale 1ns/1ps
`default_nettype none

module tbFpDivide32 import fp32Pkg::*; ();

	// operations issued over the whole run
	localparam int NUM_OPS = 89;
	// each op takes about DIV_LATENCY+2 edges, plus reset and slack
	localparam int TIMEOUT_CYCLES = NUM_OPS * (DIV_LATENCY + 4) + 100;

	logic clk;
	logic rst;
	logic ce;
	logic ld;
	roundMode_e rm;
	FP32 a;
	FP32 b;
	FP32 out;
	logic done;
	logic signExe;
	logic overflow;
	logic underflow;

	int errCount = 0;
	int checkCount = 0;
	int testCount = 0;
	int cycles = 0;

	fpDivide32nr u_dut (
		.clk(clk), .rst(rst), .ce(ce), .ld(ld), .rm(rm), .a(a), .b(b),
		.out(out), .done(done), .signExe(signExe),
		.overflow(overflow), .underflow(underflow)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("run stopped after %0d cycles, the DUT never finished", cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	// --------------------------------------------------
	// reference model
	// --------------------------------------------------
	// single to double, zero exponent flushes to zero
	function automatic real toReal(input FP32 x);
		logic [63:0] bits;
		if (x.exp == '0) begin
			bits = {x.sign, 63'd0};
		end else begin
			bits = {x.sign, 11'(int'(x.exp) - 127 + 1023), x.frac, 29'd0};
		end
		return $bitstoreal(bits);
	endfunction

	// double to single under a rounding mode, flush to zero below normal
	function automatic FP32 fromReal(input real r, input roundMode_e m);
		logic [63:0] bits;
		logic s;
		int e;
		logic [22:0] fr;
		logic g;
		logic st;
		logic inc;
		logic [23:0] sum;
		logic toMax;
		FP32 res;
		bits = $realtobits(r);
		s = bits[63];
		e = int'(bits[62:52]) - 1023 + 127;
		fr = bits[51:29];
		g = bits[28];
		st = |bits[27:0];
		// modes that never round away from zero on this sign
		toMax = (m == rmTowardZero) || (m == rmDown && !s) || (m == rmUp && s);
		case (m)
			rmNearestEven: inc = g & (st | fr[0]);
			rmTowardZero:  inc = 1'b0;
			rmDown:        inc = s & (g | st);
			rmUp:          inc = ~s & (g | st);
			default:       inc = g;
		endcase
		sum = {1'b0, fr} + 24'(inc);
		if (bits[62:52] == '0 || e <= 0) begin
			res = {s, 31'd0};
		end else if (e >= 255) begin
			res = toMax ? {s, 8'hFE, 23'h7FFFFF} : {s, 8'hFF, 23'd0};
		end else begin
			// carry out of the fraction bumps the exponent
			if (sum[23]) begin
				e = e + 1;
			end
			if (e >= 255) begin
				res = {s, 8'hFF, 23'd0};
			end else begin
				res = {s, 8'(e), sum[22:0]};
			end
		end
		return res;
	endfunction

	// --------------------------------------------------
	// checking and driving
	// --------------------------------------------------
	task automatic checkVal(input string name, input logic [31:0] expV, input logic [31:0] actV);
		checkCount++;
		assert (actV === expV) else begin
			$display("CHECK FAILED at %0t: %s expected %08h, got %08h", $time, name, expV, actV);
			errCount++;
		end
	endtask

	// load at one edge, release at the next, then count edges until done
	// busyLd > 0 fires a second load that many edges into the run
	task automatic runDiv(input FP32 x, input FP32 y, input roundMode_e m, input int busyLd);
		int lat;
		@(posedge clk);
		a <= x;
		b <= y;
		rm <= m;
		ld <= 1'b1;
		@(posedge clk);
		ld <= 1'b0;
		lat = 0;
		@(negedge clk);
		checkVal("done after ld", 32'd0, 32'(done));
		while (!done && lat <= DIV_LATENCY + 4) begin
			@(posedge clk);
			lat++;
			if (lat == busyLd) begin
				// swapped operands, this load must be dropped
				a <= y;
				b <= x;
				ld <= 1'b1;
			end else begin
				ld <= 1'b0;
			end
			@(negedge clk);
		end
		if (!done) begin
			$display("done did not rise within %0d cycles of the load at %0t", lat, $time);
			errCount++;
		end
		checkVal("latency", 32'(DIV_LATENCY), 32'(lat));
	endtask

	task automatic doDiv(input FP32 x, input FP32 y, input roundMode_e m, input FP32 expOut,
			input logic expOv, input logic expUn, input int busyLd);
		runDiv(x, y, m, busyLd);
		checkVal("out", expOut, out);
		checkVal("overflow", 32'(expOv), 32'(overflow));
		checkVal("underflow", 32'(expUn), 32'(underflow));
		// set only when both operands are negative
		checkVal("signExe", 32'(x.sign & y.sign), 32'(signExe));
	endtask

	task automatic reportTest(input string name, input int errBefore);
		testCount++;
		$display("test %-8s finished, %0d errors", name, errCount - errBefore);
	endtask

	// --------------------------------------------------
	// directed tests
	// --------------------------------------------------
	task automatic testReset();
		int e0;
		e0 = errCount;
		@(negedge clk);
		checkVal("done", 32'd1, 32'(done));
		checkVal("out", 32'd0, out);
		checkVal("overflow", 32'd0, 32'(overflow));
		checkVal("underflow", 32'd0, 32'(underflow));
		checkVal("signExe", 32'd0, 32'(signExe));
		reportTest("reset", e0);
	endtask

	task automatic testTiming();
		int e0;
		FP32 x;
		FP32 y;
		e0 = errCount;
		x = fromReal(1.5, rmNearestEven);
		y = fromReal(0.5, rmNearestEven);
		// second load mid-run, result and latency stay those of 1.5/0.5
		doDiv(x, y, rmNearestEven, fromReal(3.0, rmNearestEven), 1'b0, 1'b0, 6);
		reportTest("timing", e0);
	endtask

	task automatic exactCase(input real p, input real q);
		FP32 x;
		FP32 y;
		x = fromReal(p, rmNearestEven);
		y = fromReal(q, rmNearestEven);
		doDiv(x, y, rmNearestEven, fromReal(toReal(x) / toReal(y), rmNearestEven),
			1'b0, 1'b0, 0);
	endtask

	task automatic testExact();
		int e0;
		e0 = errCount;
		exactCase(6.0, 3.0);
		exactCase(1.0, 4.0);
		exactCase(-7.5, 2.5);
		exactCase(1.0, 1.0);
		reportTest("exact", e0);
	endtask

	task automatic testRandom();
		int e0;
		FP32 x;
		FP32 y;
		e0 = errCount;
		for (int n = 0; n < 60; n++) begin
			// exponents 70..184 keep the quotient normal
			x = {1'($urandom), 8'(70 + $urandom % 115), 23'($urandom)};
			y = {1'($urandom), 8'(70 + $urandom % 115), 23'($urandom)};
			doDiv(x, y, rmNearestEven, fromReal(toReal(x) / toReal(y), rmNearestEven),
				1'b0, 1'b0, 0);
			checkVal("out.sign", 32'(x.sign ^ y.sign), 32'(out.sign));
		end
		reportTest("random", e0);
	endtask

	task automatic testRounding();
		int e0;
		FP32 x;
		FP32 y;
		roundMode_e m;
		e0 = errCount;
		y = fromReal(3.0, rmNearestEven);
		for (int k = 0; k < 5; k++) begin
			m = roundMode_e'(3'(k));
			x = fromReal(1.0, rmNearestEven);
			doDiv(x, y, m, fromReal(toReal(x) / toReal(y), m), 1'b0, 1'b0, 0);
			// negative quotient flips the up and down results
			x = fromReal(-2.0, rmNearestEven);
			doDiv(x, y, m, fromReal(toReal(x) / toReal(y), m), 1'b0, 1'b0, 0);
		end
		reportTest("rounding", e0);
	endtask

	task automatic testSpecial();
		int e0;
		FP32 five;
		FP32 one;
		e0 = errCount;
		five = fromReal(5.0, rmNearestEven);
		one = fromReal(1.0, rmNearestEven);
		doDiv(32'h00000000, 32'h00000000, rmNearestEven, {1'b0, 8'hFF, QZEROZERO}, 1'b0, 1'b0, 0);
		doDiv(32'h7F800000, 32'h7F800000, rmNearestEven, {1'b0, 8'hFF, QINFDIV}, 1'b0, 1'b0, 0);
		doDiv(32'hFF800000, 32'h7F800000, rmNearestEven, {1'b1, 8'hFF, QINFDIV}, 1'b0, 1'b0, 0);
		// signed infinity from a zero divisor
		doDiv(five, 32'h00000000, rmNearestEven, 32'h7F800000, 1'b0, 1'b0, 0);
		doDiv({1'b1, five[30:0]}, 32'h00000000, rmNearestEven, 32'hFF800000, 1'b0, 1'b0, 0);
		// signed zero from an infinite divisor
		doDiv(five, 32'hFF800000, rmNearestEven, 32'h80000000, 1'b0, 1'b0, 0);
		doDiv(fromReal(-3.0, rmNearestEven), 32'hFF800000, rmNearestEven, 32'h00000000,
			1'b0, 1'b0, 0);
		// signaling NaNs come out quiet with the payload kept
		doDiv(32'h7F800001, one, rmNearestEven, 32'h7FC00001, 1'b0, 1'b0, 0);
		doDiv(one, 32'h7FA00000, rmNearestEven, 32'h7FE00000, 1'b0, 1'b0, 0);
		reportTest("special", e0);
	endtask

	task automatic testRange();
		int e0;
		FP32 maxN;
		FP32 minN;
		FP32 two;
		e0 = errCount;
		maxN = 32'h7F7FFFFF;
		minN = 32'h00800000;
		two = fromReal(2.0, rmNearestEven);
		doDiv(maxN, minN, rmNearestEven, fromReal(toReal(maxN) / toReal(minN), rmNearestEven),
			1'b1, 1'b0, 0);
		doDiv(maxN, minN, rmTowardZero, fromReal(toReal(maxN) / toReal(minN), rmTowardZero),
			1'b1, 1'b0, 0);
		doDiv(minN, maxN, rmNearestEven, fromReal(toReal(minN) / toReal(maxN), rmNearestEven),
			1'b0, 1'b1, 0);
		// denormal operand reads as zero
		doDiv(32'h00400000, two, rmNearestEven, 32'h00000000, 1'b0, 1'b0, 0);
		doDiv(two, 32'h00400000, rmNearestEven, 32'h7F800000, 1'b0, 1'b0, 0);
		reportTest("range", e0);
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin
		rst = 1'b1;
		ce = 1'b1;
		ld = 1'b0;
		a = '0;
		b = '0;
		rm = rmNearestEven;
		void'($urandom(96));
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		testReset();
		testTiming();
		testExact();
		testRandom();
		testRounding();
		testSpecial();
		testRange();
		$display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errCount);
		if (errCount == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
fp32Pkg.sv
fpDecomp32Reg.sv
fpMantDivider.sv
fpDivide32.sv
fpNormalize32.sv
fpRound32.sv
fpDivide32nr.sv
tbFpDivide32.sv

// File: runSim.sh
#!/bin/sh
# build and run the FP32 divider testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tbFpDivide32 -o simFpDivide32

simOut=$(./obj_dir/simFpDivide32)
echo "$simOut"

# pass only when the testbench printed its pass line
echo "$simOut" | grep -qx "TB PASSED"
